/* verilog.f */
verilog/vga_pkg.sv
verilog/sprite_pkg.sv
verilog/pixel_bus_if.sv
verilog/vga_timing.sv
verilog/tile_window.sv
verilog/game_cover.sv
verilog/pixel_out.sv
verilog/cover_screen.sv
bench/tb_clock_gen.sv
bench/tb_cover_screen.sv

/* bench/tb_cover_screen.sv */
module tb_cover_screen;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int  SHEET_SIZE   = 43200;   // 240 x 180 sheet
    localparam int  FRAME_CYCLES = int'(vga_pkg::H_TOTAL) * int'(vga_pkg::V_TOTAL);
    localparam int  RUN_CYCLES   = 2 * FRAME_CYCLES;
    localparam int  CYCLE_LIMIT  = RUN_CYCLES + 1000;
    localparam time DRIVE_DELAY  = 10ns;

    logic                    clk;
    logic                    rst_n;
    sprite_pkg::sheet_addr_t sprite_addr;
    logic                    sprite_en;
    logic                    rom_data;
    logic                    hsync;
    logic                    vsync;
    vga_pkg::rgb_t           rgb;

    logic sheet [SHEET_SIZE];   // model of the letter sheet memory
    int   cycle_count;

    tb_clock_gen u_clk (.clk(clk));

    cover_screen dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .sprite_addr (sprite_addr),
        .sprite_en   (sprite_en),
        .rom_data    (rom_data),
        .hsync       (hsync),
        .vsync       (vsync),
        .rgb         (rgb)
    );

    function automatic logic sheet_read(input sprite_pkg::sheet_addr_t a);
        if ($isunknown(a) || int'(a) >= SHEET_SIZE) return 1'b0;
        return sheet[a];
    endfunction

    // scan position on the bus in cycle k after reset release
    function automatic vga_pkg::coord_t pos_h(input int k);
        return vga_pkg::coord_t'(k % int'(vga_pkg::H_TOTAL));
    endfunction

    function automatic vga_pkg::coord_t pos_v(input int k);
        return vga_pkg::coord_t'((k / int'(vga_pkg::H_TOTAL)) % int'(vga_pkg::V_TOTAL));
    endfunction

    function automatic logic exp_active(input vga_pkg::coord_t h, input vga_pkg::coord_t v);
        return (h < vga_pkg::H_ACTIVE) && (v < vga_pkg::V_ACTIVE);
    endfunction

    // first tile in priority order that covers the position, -1 if none
    function automatic int first_tile(input vga_pkg::coord_t h, input vga_pkg::coord_t v);
        int ph;
        int pv;
        for (int i = 0; i < sprite_pkg::N_TILES; i++) begin
            ph = int'(sprite_pkg::TILE_PIVOT_H[i]);
            pv = int'(sprite_pkg::TILE_PIVOT_V[i]);
            if (int'(h) >= ph && int'(h) < ph + int'(sprite_pkg::TILE_W) &&
                int'(v) >= pv && int'(v) < pv + int'(sprite_pkg::TILE_H)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic exp_en(input vga_pkg::coord_t h, input vga_pkg::coord_t v);
        return exp_active(h, v) && (first_tile(h, v) >= 0);
    endfunction

    function automatic sprite_pkg::sheet_addr_t exp_addr(input vga_pkg::coord_t h,
                                                         input vga_pkg::coord_t v);
        int idx;
        int row;
        int col;
        idx = first_tile(h, v);
        if (idx < 0) return '0;
        row = int'(v) - int'(sprite_pkg::TILE_PIVOT_V[idx]) + int'(sprite_pkg::TILE_MEM_V[idx]);
        col = int'(h) - int'(sprite_pkg::TILE_PIVOT_H[idx]) + int'(sprite_pkg::TILE_MEM_H[idx]);
        return sprite_pkg::sheet_addr_t'(row * int'(sprite_pkg::SHEET_W) + col);
    endfunction

    function automatic logic exp_hsync(input vga_pkg::coord_t h);
        return !(h >= vga_pkg::H_SYNC_START && h < vga_pkg::H_SYNC_END);
    endfunction

    function automatic logic exp_vsync(input vga_pkg::coord_t v);
        return !(v >= vga_pkg::V_SYNC_START && v < vga_pkg::V_SYNC_END);
    endfunction

    function automatic vga_pkg::rgb_t exp_rgb(input vga_pkg::coord_t h, input vga_pkg::coord_t v);
        if (!exp_active(h, v)) return '0;
        if (exp_en(h, v) && sheet_read(exp_addr(h, v))) return vga_pkg::FG_COLOR;
        return vga_pkg::BG_COLOR;
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input sprite_pkg::sheet_addr_t got,
                              input sprite_pkg::sheet_addr_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s expected %0d got %0d", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s expected %b got %b", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_rgb(input string name, input vga_pkg::rgb_t got,
                             input vga_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    // address outputs lag the bus by one cycle, pixel outputs by three
    task automatic check_cycle(input int k);
        vga_pkg::coord_t h;
        vga_pkg::coord_t v;
        if (k >= 1) begin
            h = pos_h(k - 1);
            v = pos_v(k - 1);
            check_bit("sprite_en", sprite_en, exp_en(h, v));
            if (exp_en(h, v)) check_addr("sprite_addr", sprite_addr, exp_addr(h, v));
        end else begin
            check_bit("sprite_en", sprite_en, 1'b0);
        end
        if (k >= 3) begin
            h = pos_h(k - 3);
            v = pos_v(k - 3);
            check_rgb("rgb", rgb, exp_rgb(h, v));
            check_bit("hsync", hsync, exp_hsync(h));
            check_bit("vsync", vsync, exp_vsync(v));
        end else begin
            check_rgb("rgb", rgb, '0);      // pipeline still holds reset values
            check_bit("hsync", hsync, 1'b1);
            check_bit("vsync", vsync, 1'b1);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h9970));
        for (int i = 0; i < SHEET_SIZE; i++) begin
            sheet[i] = 1'($urandom() % 2);
        end
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
    end

    // sheet memory, one clock of read latency
    initial begin
        sprite_pkg::sheet_addr_t addr_smp;
        rom_data = 1'b0;
        forever begin
            @(negedge clk);
            addr_smp = sprite_addr;
            @(posedge clk);
            #(DRIVE_DELAY);
            rom_data = sheet_read(addr_smp);
        end
    end

    initial begin
        @(posedge clk);
        @(negedge clk);
        check_bit("sprite_en", sprite_en, 1'b0);    // in reset
        check_rgb("rgb", rgb, '0);
        check_bit("hsync", hsync, 1'b1);
        check_bit("vsync", vsync, 1'b1);
        wait (rst_n === 1'b1);
        for (int k = 0; k < RUN_CYCLES + 3; k++) begin
            @(negedge clk);
            check_cycle(k);
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: two frames were not checked within %0d cycles", CYCLE_LIMIT);
        abort_run();
    end

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam time HALF_PERIOD = 50ns;    // 100 ns pixel clock

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk = ~clk;
        end
    end

endmodule

/* verilog/cover_screen.sv */
module cover_screen (
    input  logic                    clk,
    input  logic                    rst_n,
    output sprite_pkg::sheet_addr_t sprite_addr,
    output logic                    sprite_en,
    input  logic                    rom_data,
    output logic                    hsync,
    output logic                    vsync,
    output vga_pkg::rgb_t           rgb
);

    pixel_bus_if bus ();

    vga_timing u_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.source)
    );

    // address goes out to the sheet memory
    game_cover u_cover (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus.mapper),
        .sprite_addr (sprite_addr),
        .sprite_en   (sprite_en)
    );

    // rom_data comes back one clock after sprite_addr
    pixel_out u_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus.sink),
        .sprite_en (sprite_en),
        .rom_data  (rom_data),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync)
    );

endmodule

/* verilog/pixel_out.sv */
module pixel_out (
    input  logic          clk,
    input  logic          rst_n,
    pixel_bus_if.sink     bus,
    input  logic          sprite_en,
    input  logic          rom_data,
    output vga_pkg::rgb_t rgb,
    output logic          hsync,
    output logic          vsync
);

    logic [2:0] act_q;
    logic [2:0] hs_q;
    logic [2:0] vs_q;
    logic       en_q;   // lines up with rom_data

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_q <= '0;
            hs_q  <= '1;    // syncs idle high
            vs_q  <= '1;
            en_q  <= 1'b0;
        end else begin
            act_q <= {act_q[1:0], bus.active};
            hs_q  <= {hs_q[1:0], bus.hsync};
            vs_q  <= {vs_q[1:0], bus.vsync};
            en_q  <= sprite_en;
        end
    end

    // act_q[1] is the flag of the pixel whose sheet bit is on rom_data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (!act_q[1]) begin
            rgb <= '0;                  // blanking
        end else if (en_q && rom_data) begin
            rgb <= vga_pkg::FG_COLOR;
        end else begin
            rgb <= vga_pkg::BG_COLOR;
        end
    end

    assign hsync = hs_q[2];
    assign vsync = vs_q[2];

    // colour must stay dark outside the visible area
    a_blank_dark: assert property (
        @(posedge clk) disable iff (!rst_n)
        !act_q[2] |-> (rgb == '0)
    );

endmodule

/* verilog/game_cover.sv */
module game_cover (
    input  logic                    clk,
    input  logic                    rst_n,
    pixel_bus_if.mapper             bus,
    output sprite_pkg::sheet_addr_t sprite_addr,
    output logic                    sprite_en
);

    logic [sprite_pkg::N_TILES-1:0] hit;
    sprite_pkg::sheet_addr_t        tile_addr [sprite_pkg::N_TILES];
    logic                           any_hit;
    sprite_pkg::sheet_addr_t        win_addr;

    for (genvar i = 0; i < sprite_pkg::N_TILES; i++) begin : g_tile
        tile_window #(
            .pivot_h     (sprite_pkg::TILE_PIVOT_H[i]),
            .pivot_v     (sprite_pkg::TILE_PIVOT_V[i]),
            .mem_pivot_h (sprite_pkg::TILE_MEM_H[i]),
            .mem_pivot_v (sprite_pkg::TILE_MEM_V[i])
        ) u_tile (
            .h    (bus.h),
            .v    (bus.v),
            .hit  (hit[i]),
            .addr (tile_addr[i])
        );
    end

    // walk from the back so the lowest index is written last
    always_comb begin
        any_hit  = 1'b0;
        win_addr = '0;
        for (int i = sprite_pkg::N_TILES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                any_hit  = 1'b1;
                win_addr = tile_addr[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sprite_en <= 1'b0;
        end else begin
            sprite_en <= any_hit && bus.active;
        end
    end

    always_ff @(posedge clk) begin
        sprite_addr <= win_addr;    // sheet read issued next cycle
    end

    // a letter fetch always belongs to a visible pixel
    a_en_active: assert property (
        @(posedge clk) disable iff (!rst_n)
        sprite_en |-> $past(bus.active)
    );

endmodule

/* verilog/tile_window.sv */
module tile_window #(
    parameter vga_pkg::coord_t pivot_h     = '0,
    parameter vga_pkg::coord_t pivot_v     = '0,
    parameter vga_pkg::coord_t mem_pivot_h = '0,
    parameter vga_pkg::coord_t mem_pivot_v = '0
) (
    input  vga_pkg::coord_t         h,
    input  vga_pkg::coord_t         v,
    output logic                    hit,
    output sprite_pkg::sheet_addr_t addr
);

    sprite_pkg::sheet_addr_t row;
    sprite_pkg::sheet_addr_t col;
    logic                    in_h;
    logic                    in_v;

    assign in_h = (h >= pivot_h) && (h < pivot_h + sprite_pkg::TILE_W);
    assign in_v = (v >= pivot_v) && (v < pivot_v + sprite_pkg::TILE_H);
    assign hit  = in_h && in_v;

    // shift screen position into sheet space
    // wraps outside the window, only used while hit
    assign row = sprite_pkg::sheet_addr_t'(v)
               - sprite_pkg::sheet_addr_t'(pivot_v)
               + sprite_pkg::sheet_addr_t'(mem_pivot_v);
    assign col = sprite_pkg::sheet_addr_t'(h)
               - sprite_pkg::sheet_addr_t'(pivot_h)
               + sprite_pkg::sheet_addr_t'(mem_pivot_h);

    assign addr = row * sprite_pkg::SHEET_W + col;

endmodule

/* verilog/vga_timing.sv */
module vga_timing (
    input  logic        clk,
    input  logic        rst_n,
    pixel_bus_if.source bus
);

    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;
    logic            line_end;
    logic            frame_end;

    assign line_end  = (h_cnt == vga_pkg::H_TOTAL - 10'd1);
    assign frame_end = (v_cnt == vga_pkg::V_TOTAL - 10'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;  // next line
            end
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    assign bus.h = h_cnt;
    assign bus.v = v_cnt;

    assign bus.active = (h_cnt < vga_pkg::H_ACTIVE) && (v_cnt < vga_pkg::V_ACTIVE);

    // sync pulses sit in the blanking interval
    assign bus.hsync = !((h_cnt >= vga_pkg::H_SYNC_START) &&
                         (h_cnt <  vga_pkg::H_SYNC_END));
    assign bus.vsync = !((v_cnt >= vga_pkg::V_SYNC_START) &&
                         (v_cnt <  vga_pkg::V_SYNC_END));

    // counters never leave the frame
    a_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        (h_cnt < vga_pkg::H_TOTAL) && (v_cnt < vga_pkg::V_TOTAL)
    );

endmodule

/* verilog/pixel_bus_if.sv */
interface pixel_bus_if;

    vga_pkg::coord_t h;         // scan column
    vga_pkg::coord_t v;         // scan line
    logic            active;    // inside 640x480
    logic            hsync;     // active low
    logic            vsync;     // active low

    modport source (
        output h, v, active, hsync, vsync
    );

    modport mapper (
        input h, v, active
    );

    modport sink (
        input active, hsync, vsync
    );

endinterface

/* verilog/sprite_pkg.sv */
package sprite_pkg;

    // index into the one-bit letter sheet
    typedef logic [15:0] sheet_addr_t;

    localparam sheet_addr_t SHEET_W = 16'd240;  // pixels per sheet row

    localparam vga_pkg::coord_t TILE_W = 10'd25;
    localparam vga_pkg::coord_t TILE_H = 10'd40;

    localparam int N_TILES = 14;

    // priority order: e s c a p e2 f r o m n t h u
    // lower index wins where tiles overlap

    // top-left corner of each tile on screen
    localparam vga_pkg::coord_t TILE_PIVOT_H [N_TILES] = '{
        10'd5,   10'd30,  10'd55,  10'd80,  10'd105, 10'd130, 10'd30,
        10'd55,  10'd80,  10'd105, 10'd30,  10'd55,  10'd80,  10'd105
    };

    localparam vga_pkg::coord_t TILE_PIVOT_V [N_TILES] = '{
        10'd0,   10'd5,   10'd5,   10'd5,   10'd5,   10'd5,   10'd40,
        10'd40,  10'd40,  10'd40,  10'd80,  10'd80,  10'd80,  10'd80
    };

    // top-left corner of each letter in the sheet
    // e and e2 point at the same glyph
    localparam vga_pkg::coord_t TILE_MEM_H [N_TILES] = '{
        10'd108, 10'd8,   10'd58,  10'd8,   10'd158, 10'd108, 10'd133,
        10'd208, 10'd133, 10'd83,  10'd108, 10'd33,  10'd183, 10'd58
    };

    localparam vga_pkg::coord_t TILE_MEM_V [N_TILES] = '{
        10'd5,   10'd90,  10'd5,   10'd5,   10'd50,  10'd5,   10'd5,
        10'd50,  10'd50,  10'd50,  10'd50,  10'd90,  10'd5,   10'd135
    };

endpackage

/* verilog/vga_pkg.sv */
package vga_pkg;

    // screen coordinate, wide enough for both counters
    typedef logic [9:0] coord_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] rgb_t;

    // horizontal timing in pixel clocks
    localparam coord_t H_ACTIVE     = 10'd640;
    localparam coord_t H_SYNC_START = 10'd656;
    localparam coord_t H_SYNC_END   = 10'd752;
    localparam coord_t H_TOTAL      = 10'd800;

    // vertical timing in lines
    localparam coord_t V_ACTIVE     = 10'd480;
    localparam coord_t V_SYNC_START = 10'd490;
    localparam coord_t V_SYNC_END   = 10'd492;
    localparam coord_t V_TOTAL      = 10'd525;

    localparam rgb_t FG_COLOR = 12'hfc0;    // letters, warm yellow
    localparam rgb_t BG_COLOR = 12'h014;    // cover background, deep blue

endpackage
